// File: rtl/pci_pkg.sv
// Shared PCI target types and sizes; 32-bit bus only, tristates modelled as split in/out/oe
`default_nettype none

package pci_pkg;

   // *******************************************************************
   // Identity and sizes
   // *******************************************************************
   localparam logic [15:0] VENDOR_ID = 16'h1E5A;
   localparam logic [15:0] DEVICE_ID = 16'h0C41;

   localparam int MEM_WORDS       = 64;
   localparam int MEM_ADR_BITS    = $clog2(MEM_WORDS);
   localparam int BAR_SIZE_BITS   = 8;
   localparam int MEM_WAIT_CYCLES = 2;
   localparam int WAIT_CNT_BITS   = $clog2(MEM_WAIT_CYCLES + 1);
   localparam int DOORBELL_INDEX  = 63;

   // Config dword index taken from ad[7:2]
   localparam int CFG_INDEX_BITS = 6;
   localparam logic [CFG_INDEX_BITS-1:0] CFG_ID_INDEX   = 6'd0;
   localparam logic [CFG_INDEX_BITS-1:0] CFG_CMD_INDEX  = 6'd1;
   localparam logic [CFG_INDEX_BITS-1:0] CFG_BAR0_INDEX = 6'd4;

   // Command register bits, and status bit counted from bit 16
   localparam int CMD_MEM_EN_BIT  = 1;
   localparam int CMD_INT_DIS_BIT = 10;
   localparam int STAT_INT_BIT    = 3;

   // *******************************************************************
   // Bus commands and target states
   // *******************************************************************
   typedef enum logic [3:0] {
      MEM_READ  = 4'h6,
      MEM_WRITE = 4'h7,
      CFG_READ  = 4'hA,
      CFG_WRITE = 4'hB
   } pci_cmd_e;

   typedef enum logic [2:0] {
      IDLE,
      CFG_WAIT,
      MEM_WAIT_IRDY,
      MEM_WAIT_LOCAL,
      DATA,
      TURNAROUND,
      IGNORE
   } tgt_state_e;

   // *******************************************************************
   // Bus and local-side bundles
   // *******************************************************************
   typedef struct packed {
      logic        frame_n;
      logic        irdy_n;
      logic        idsel;
      logic [3:0]  cbe_n;
      logic [31:0] ad;
   } pci_bus_in_t;

   typedef struct packed {
      logic        devsel_n;
      logic        trdy_n;
      logic        stop_n;
      logic        ad_oe;
      logic [31:0] ad;
   } pci_bus_out_t;

   typedef struct packed {
      logic                    lt_frame;
      logic                    write;
      logic [MEM_ADR_BITS-1:0] adr;
      logic [3:0]              ben;
      logic [31:0]             dat;
   } local_req_t;

   typedef struct packed {
      logic        lt_rdy;
      logic [31:0] adi;
   } local_rsp_t;

endpackage

`default_nettype wire

// File: rtl/pci_cfg_space.sv
// Type 0 header only: IDs, command/status and BAR0; config writes take the whole dword
`timescale 1ns/100ps
`default_nettype none

module pci_cfg_space (
   input  logic                                clk,
   input  logic                                reset,
   input  logic [pci_pkg::CFG_INDEX_BITS-1:0]  cfg_index,
   input  logic                                cfg_write,
   input  logic                                cfg_strobe,
   input  logic [31:0]                         cfg_wdata,
   output logic [31:0]                         cfg_rdata,
   output logic [31-pci_pkg::BAR_SIZE_BITS:0]  bar_base,
   output logic                                mem_en,
   input  logic                                irq_pending,
   output logic                                inta_n
);

   // Only the implemented command bits are stored
   logic                                mem_en_q;
   logic                                int_dis_q;
   logic [31-pci_pkg::BAR_SIZE_BITS:0]  bar_q;
   logic                                inta_q;

   always_ff @(posedge clk) begin
      if (reset) begin
         mem_en_q  <= 1'b0;
         int_dis_q <= 1'b0;
         bar_q     <= '0;
         inta_q    <= 1'b1;
      end else begin
         // Level interrupt, masked by interrupt-disable
         inta_q <= !(irq_pending && !int_dis_q);
         if (cfg_strobe && cfg_write) begin
            case (cfg_index)
               pci_pkg::CFG_CMD_INDEX: begin
                  mem_en_q  <= cfg_wdata[pci_pkg::CMD_MEM_EN_BIT];
                  int_dis_q <= cfg_wdata[pci_pkg::CMD_INT_DIS_BIT];
               end
               pci_pkg::CFG_BAR0_INDEX: begin
                  bar_q <= cfg_wdata[31:pci_pkg::BAR_SIZE_BITS];
               end
               default: begin
               end
            endcase
         end
      end
   end

   // Read mux, unimplemented dwords return zero
   always_comb begin
      cfg_rdata = '0;
      case (cfg_index)
         pci_pkg::CFG_ID_INDEX: begin
            cfg_rdata = {pci_pkg::DEVICE_ID, pci_pkg::VENDOR_ID};
         end
         pci_pkg::CFG_CMD_INDEX: begin
            cfg_rdata[pci_pkg::CMD_MEM_EN_BIT]    = mem_en_q;
            cfg_rdata[pci_pkg::CMD_INT_DIS_BIT]   = int_dis_q;
            // Status half, interrupt status is read only
            cfg_rdata[16 + pci_pkg::STAT_INT_BIT] = irq_pending;
         end
         pci_pkg::CFG_BAR0_INDEX: begin
            // 32-bit non-prefetchable memory BAR, size bits read zero
            cfg_rdata = {bar_q, {pci_pkg::BAR_SIZE_BITS{1'b0}}};
         end
         default: begin
            cfg_rdata = '0;
         end
      endcase
   end

   assign bar_base = bar_q;
   assign mem_en   = mem_en_q;
   assign inta_n   = inta_q;

endmodule

`default_nettype wire

// File: rtl/pci_target_fsm.sv
// Single-dword target: bursts are disconnected with data; no retry, abort, parity or I/O space
`timescale 1ns/100ps
`default_nettype none

module pci_target_fsm (
   input  logic                                clk,
   input  logic                                reset,
   input  pci_pkg::pci_bus_in_t                bus_in,
   output pci_pkg::pci_bus_out_t               bus_out,
   output logic [pci_pkg::CFG_INDEX_BITS-1:0]  cfg_index,
   output logic                                cfg_write,
   output logic                                cfg_strobe,
   output logic [31:0]                         cfg_wdata,
   input  logic [31:0]                         cfg_rdata,
   input  logic [31-pci_pkg::BAR_SIZE_BITS:0]  bar_base,
   input  logic                                mem_en,
   output pci_pkg::local_req_t                 lreq,
   input  pci_pkg::local_rsp_t                 lrsp
);

   pci_pkg::tgt_state_e                 state_q;
   pci_pkg::pci_bus_out_t               out_q;
   pci_pkg::local_req_t                 req_q;
   pci_pkg::pci_cmd_e                   cmd;
   logic [pci_pkg::CFG_INDEX_BITS-1:0]  index_q;
   logic                                write_q;
   logic                                cfg_q;
   logic                                burst_q;
   logic                                cmd_is_cfg;
   logic                                cmd_is_mem;
   logic                                cmd_is_write;
   logic                                cfg_hit;
   logic                                mem_hit;

   // *******************************************************************
   // Address phase decode
   // *******************************************************************
   assign cmd          = pci_pkg::pci_cmd_e'(bus_in.cbe_n);
   assign cmd_is_cfg   = (cmd == pci_pkg::CFG_READ) || (cmd == pci_pkg::CFG_WRITE);
   assign cmd_is_mem   = (cmd == pci_pkg::MEM_READ) || (cmd == pci_pkg::MEM_WRITE);
   assign cmd_is_write = (cmd == pci_pkg::MEM_WRITE) || (cmd == pci_pkg::CFG_WRITE);

   // Type 0 config needs idsel and ad[1:0] of 00
   assign cfg_hit = bus_in.idsel && (bus_in.ad[1:0] == 2'b00) && cmd_is_cfg;
   assign mem_hit = mem_en && (bus_in.ad[31:pci_pkg::BAR_SIZE_BITS] == bar_base) && cmd_is_mem;

   // *******************************************************************
   // Target state machine
   // *******************************************************************
   always_ff @(posedge clk) begin
      if (reset) begin
         state_q        <= pci_pkg::IDLE;
         out_q.devsel_n <= 1'b1;
         out_q.trdy_n   <= 1'b1;
         out_q.stop_n   <= 1'b1;
         out_q.ad_oe    <= 1'b0;
         req_q.lt_frame <= 1'b0;
      end else begin
         req_q.lt_frame <= 1'b0;
         unique case (state_q)
            pci_pkg::IDLE: begin
               if (!bus_in.frame_n) begin
                  index_q <= bus_in.ad[2 +: pci_pkg::CFG_INDEX_BITS];
                  write_q <= cmd_is_write;
                  cfg_q   <= cmd_is_cfg;
                  if (cfg_hit) begin
                     out_q.devsel_n <= 1'b0;
                     state_q        <= pci_pkg::CFG_WAIT;
                  end else if (mem_hit) begin
                     out_q.devsel_n <= 1'b0;
                     state_q        <= pci_pkg::MEM_WAIT_IRDY;
                  end else begin
                     state_q <= pci_pkg::IGNORE;
                  end
               end
            end
            pci_pkg::CFG_WAIT: begin
               // Fixed one cycle of decode, then data goes out
               out_q.trdy_n <= 1'b0;
               out_q.ad_oe  <= !write_q;
               out_q.ad     <= cfg_rdata;
               // Master already showing a second phase
               out_q.stop_n <= bus_in.frame_n || bus_in.irdy_n;
               state_q      <= pci_pkg::DATA;
            end
            pci_pkg::MEM_WAIT_IRDY: begin
               if (!bus_in.irdy_n) begin
                  req_q.lt_frame <= 1'b1;
                  req_q.write    <= write_q;
                  req_q.adr      <= index_q[pci_pkg::MEM_ADR_BITS-1:0];
                  req_q.ben      <= ~bus_in.cbe_n;
                  req_q.dat      <= bus_in.ad;
                  burst_q        <= !bus_in.frame_n;
                  state_q        <= pci_pkg::MEM_WAIT_LOCAL;
               end
            end
            pci_pkg::MEM_WAIT_LOCAL: begin
               if (lrsp.lt_rdy) begin
                  out_q.trdy_n <= 1'b0;
                  out_q.ad_oe  <= !write_q;
                  out_q.ad     <= lrsp.adi;
                  out_q.stop_n <= !burst_q;
                  state_q      <= pci_pkg::DATA;
               end
            end
            pci_pkg::DATA: begin
               if (!out_q.trdy_n) begin
                  // ad is left alone here so read data holds through irdy_n waits
                  if (!bus_in.irdy_n) begin
                     out_q.trdy_n <= 1'b1;
                     out_q.ad_oe  <= 1'b0;
                     if (!bus_in.frame_n) begin
                        // Burst attempt, disconnect and wait for frame_n
                        out_q.stop_n <= 1'b0;
                     end else begin
                        out_q.devsel_n <= 1'b1;
                        out_q.stop_n   <= 1'b1;
                        state_q        <= pci_pkg::TURNAROUND;
                     end
                  end
               end else if (bus_in.frame_n) begin
                  out_q.devsel_n <= 1'b1;
                  out_q.stop_n   <= 1'b1;
                  state_q        <= pci_pkg::TURNAROUND;
               end
            end
            pci_pkg::TURNAROUND: begin
               state_q <= pci_pkg::IDLE;
            end
            pci_pkg::IGNORE: begin
               // Not ours, wait for the bus to go idle
               if (bus_in.frame_n && bus_in.irdy_n) begin
                  state_q <= pci_pkg::IDLE;
               end
            end
            default: begin
               state_q <= pci_pkg::IDLE;
            end
         endcase
      end
   end

   // Config access completes on the same edge as the bus data phase
   assign cfg_strobe = (state_q == pci_pkg::DATA) && cfg_q && !out_q.trdy_n && !bus_in.irdy_n;
   assign cfg_index  = index_q;
   assign cfg_write  = write_q;
   assign cfg_wdata  = bus_in.ad;

   assign bus_out = out_q;
   assign lreq    = req_q;

endmodule

`default_nettype wire

// File: rtl/local_mem_app.sv
// Local memory app: one request at a time, fixed MEM_WAIT_CYCLES latency, no reset on memory
`timescale 1ns/100ps
`default_nettype none

module local_mem_app (
   input  logic                 clk,
   input  logic                 reset,
   input  pci_pkg::local_req_t  lreq,
   output pci_pkg::local_rsp_t  lrsp,
   output logic                 irq_pending
);

   logic [31:0]                        mem [pci_pkg::MEM_WORDS];
   logic [pci_pkg::MEM_ADR_BITS-1:0]   adr_q;
   logic [pci_pkg::WAIT_CNT_BITS-1:0]  cnt_q;
   logic [31:0]                        adi_q;
   logic                               rdy_q;
   logic                               irq_q;
   logic                               rsp_due;

   // Last count of the wait
   assign rsp_due = (cnt_q == pci_pkg::WAIT_CNT_BITS'(1));

   // Byte-lane writes, read data taken on the reply edge
   always_ff @(posedge clk) begin
      if (lreq.lt_frame) begin
         adr_q <= lreq.adr;
         if (lreq.write) begin
            for (int b = 0; b < 4; b++) begin
               if (lreq.ben[b]) begin
                  mem[lreq.adr][8*b +: 8] <= lreq.dat[8*b +: 8];
               end
            end
         end
      end
      if (rsp_due) begin
         adi_q <= mem[adr_q];
      end
   end

   // Wait counter and doorbell
   always_ff @(posedge clk) begin
      if (reset) begin
         cnt_q <= '0;
         rdy_q <= 1'b0;
         irq_q <= 1'b0;
      end else begin
         rdy_q <= rsp_due;
         if (lreq.lt_frame) begin
            cnt_q <= pci_pkg::WAIT_CNT_BITS'(pci_pkg::MEM_WAIT_CYCLES);
         end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
         end
         if (lreq.lt_frame && lreq.write &&
             (lreq.adr == pci_pkg::MEM_ADR_BITS'(pci_pkg::DOORBELL_INDEX))) begin
            irq_q <= lreq.dat[0];
         end
      end
   end

   assign lrsp.lt_rdy = rdy_q;
   assign lrsp.adi    = adi_q;
   assign irq_pending = irq_q;

endmodule

`default_nettype wire

// File: rtl/pci_target_top.sv
// PCI target top; ad drive is only valid while bus_out.ad_oe is high, no pull-ups inside
`timescale 1ns/100ps
`default_nettype none

module pci_target_top (
   input  logic                   clk,
   input  logic                   reset,
   input  pci_pkg::pci_bus_in_t   bus_in,
   output pci_pkg::pci_bus_out_t  bus_out,
   output logic                   inta_n
);

   logic [pci_pkg::CFG_INDEX_BITS-1:0]  cfg_index;
   logic                                cfg_write;
   logic                                cfg_strobe;
   logic [31:0]                         cfg_wdata;
   logic [31:0]                         cfg_rdata;
   logic [31-pci_pkg::BAR_SIZE_BITS:0]  bar_base;
   logic                                mem_en;
   logic                                irq_pending;
   pci_pkg::local_req_t                 lreq;
   pci_pkg::local_rsp_t                 lrsp;

   // Bus protocol engine
   pci_target_fsm u0 (
      .clk        (clk),
      .reset      (reset),
      .bus_in     (bus_in),
      .bus_out    (bus_out),
      .cfg_index  (cfg_index),
      .cfg_write  (cfg_write),
      .cfg_strobe (cfg_strobe),
      .cfg_wdata  (cfg_wdata),
      .cfg_rdata  (cfg_rdata),
      .bar_base   (bar_base),
      .mem_en     (mem_en),
      .lreq       (lreq),
      .lrsp       (lrsp)
   );

   // Configuration header and interrupt pin
   pci_cfg_space u1 (
      .clk         (clk),
      .reset       (reset),
      .cfg_index   (cfg_index),
      .cfg_write   (cfg_write),
      .cfg_strobe  (cfg_strobe),
      .cfg_wdata   (cfg_wdata),
      .cfg_rdata   (cfg_rdata),
      .bar_base    (bar_base),
      .mem_en      (mem_en),
      .irq_pending (irq_pending),
      .inta_n      (inta_n)
   );

   // Local side application
   local_mem_app u2 (
      .clk         (clk),
      .reset       (reset),
      .lreq        (lreq),
      .lrsp        (lrsp),
      .irq_pending (irq_pending)
   );

endmodule

`default_nettype wire

// File: testbench/pci_target_chk.sv
// Bus output assertions bound into pci_target_top; fired counts failures for the testbench
`timescale 1ns/100ps
`default_nettype none

module pci_target_chk (
   input logic                   clk,
   input logic                   reset,
   input pci_pkg::pci_bus_out_t  bus_out
);

   int unsigned fired = 0;

   // Target signals only move while the cycle is claimed
   trdy_needs_devsel: assert property (@(posedge clk) disable iff (reset)
      !bus_out.trdy_n |-> !bus_out.devsel_n)
      else begin
         $error("trdy_n low while devsel_n high");
         fired++;
      end

   stop_needs_devsel: assert property (@(posedge clk) disable iff (reset)
      !bus_out.stop_n |-> !bus_out.devsel_n)
      else begin
         $error("stop_n low while devsel_n high");
         fired++;
      end

   ad_oe_needs_devsel: assert property (@(posedge clk) disable iff (reset)
      bus_out.ad_oe |-> !bus_out.devsel_n)
      else begin
         $error("ad driven while devsel_n high");
         fired++;
      end

   // Quiet bus while reset is held
   quiet_in_reset: assert property (@(posedge clk)
      reset |=> (bus_out.devsel_n && bus_out.trdy_n && bus_out.stop_n))
      else begin
         $error("target outputs active during reset");
         fired++;
      end

endmodule

bind pci_target_top pci_target_chk chk0 (
   .clk     (clk),
   .reset   (reset),
   .bus_out (bus_out)
);

`default_nettype wire

// File: testbench/pci_bus_tasks.svh
// Master-side PCI cycles; needs clk, bus_in, bus_out and report tasks from the including testbench
`ifndef PCI_BUS_TASKS_SVH
`define PCI_BUS_TASKS_SVH

   // Step just past the next rising edge where DUT outputs have settled
   task automatic next_cycle();
      @(posedge clk);
      #DRIVE_DELAY;
   endtask

   task automatic drive_idle();
      bus_in.frame_n = 1'b1;
      bus_in.irdy_n  = 1'b1;
      bus_in.idsel   = 1'b0;
      bus_in.cbe_n   = 4'hF;
      bus_in.ad      = '0;
   endtask

   // One data phase with irdy_delay cycles of master wait
   // hold_frame asks for a burst
   task automatic bus_cycle(
      input  pci_pkg::pci_cmd_e  cmd,
      input  logic [31:0]        addr,
      input  logic               idsel,
      input  logic [3:0]         ben,
      input  logic [31:0]        wdata,
      input  int                 irdy_delay,
      input  logic               hold_frame,
      output logic [31:0]        rdata,
      output logic               aborted,
      output logic               stopped
   );
      int          cycles;
      int          no_devsel;
      int          wait_left;
      logic        done;
      logic        hung;
      logic        held;
      logic        is_write;
      logic [31:0] first_ad;
      cycles    = 0;
      no_devsel = 0;
      wait_left = irdy_delay;
      done      = 1'b0;
      hung      = 1'b0;
      held      = 1'b0;
      is_write  = (cmd == pci_pkg::MEM_WRITE) || (cmd == pci_pkg::CFG_WRITE);
      first_ad  = '0;
      rdata     = '0;
      aborted   = 1'b0;
      stopped   = 1'b0;
      // Address phase
      bus_in.frame_n = 1'b0;
      bus_in.irdy_n  = 1'b1;
      bus_in.idsel   = idsel;
      bus_in.cbe_n   = cmd;
      bus_in.ad      = addr;
      next_cycle();
      bus_in.idsel = 1'b0;
      bus_in.cbe_n = ~ben;
      bus_in.ad    = is_write ? wdata : '0;
      while (!done && !aborted && !hung) begin
         if (wait_left == 0) begin
            bus_in.irdy_n  = 1'b0;
            bus_in.frame_n = !hold_frame;
         end else begin
            wait_left--;
         end
         if (!bus_out.trdy_n) begin
            // Read data has to hold through master wait states
            if (held && (bus_out.ad !== first_ad)) begin
               report_mismatch("ad while trdy_n low", bus_out.ad, first_ad);
            end
            held     = 1'b1;
            first_ad = bus_out.ad;
            if (!bus_in.irdy_n) begin
               if (bus_out.ad_oe !== !is_write) begin
                  report_mismatch("ad_oe", 32'(bus_out.ad_oe), 32'(!is_write));
               end
               rdata   = bus_out.ad_oe ? bus_out.ad : 32'hxxxx_xxxx;
               stopped = !bus_out.stop_n;
               done    = 1'b1;
            end
         end
         if (bus_out.devsel_n) begin
            no_devsel++;
         end
         if (!done && (no_devsel >= ABORT_CYCLES)) begin
            aborted = 1'b1;
         end else if (!done && (cycles >= CYCLE_LIMIT)) begin
            hung = 1'b1;
         end
         cycles++;
         next_cycle();
      end
      if (aborted) begin
         // Master abort drops frame_n first and irdy_n one cycle later
         bus_in.frame_n = 1'b1;
         bus_in.irdy_n  = 1'b0;
         next_cycle();
      end else if (hung) begin
         report_failure("Timeout, the data phase never completed");
      end else if (hold_frame) begin
         // End the disconnected burst and wait for devsel_n to rise
         bus_in.frame_n = 1'b1;
         bus_in.irdy_n  = 1'b0;
         cycles = 0;
         while (!bus_out.devsel_n && (cycles < CYCLE_LIMIT)) begin
            next_cycle();
            cycles++;
         end
         if (!bus_out.devsel_n) begin
            report_failure("Timeout, devsel_n stayed low after the disconnect");
         end
      end
      drive_idle();
      next_cycle();
      next_cycle();
   endtask

`endif

// File: testbench/pci_target_tb.sv
// Bus-master testbench; xorshift seed 1425, memory preloaded before reads, every wait is bounded
`timescale 1ns/100ps
`default_nettype none

module pci_target_tb;

   localparam int CLK_PERIOD   = 20;
   localparam int DRIVE_DELAY  = 2;
   localparam int ABORT_CYCLES = 6;
   localparam int CYCLE_LIMIT  = 32;

   logic                   clk;
   logic                   reset;
   pci_pkg::pci_bus_in_t   bus_in;
   pci_pkg::pci_bus_out_t  bus_out;
   logic                   inta_n;

   // Reference model
   logic [31:0]  model_mem [pci_pkg::MEM_WORDS];
   logic [31:0]  model_bar;
   logic         model_mem_en;
   logic         model_int_dis;
   logic         model_irq;

   logic [31:0]  rng;
   logic [31:0]  rd;
   logic [31:0]  data;
   logic         ab;
   logic         st;
   int           idx;
   int           errors;
   int           test_errors;
   int           tests_run;
   int           tests_failed;

   pci_target_top dut0 (
      .clk     (clk),
      .reset   (reset),
      .bus_in  (bus_in),
      .bus_out (bus_out),
      .inta_n  (inta_n)
   );

   `include "pci_bus_tasks.svh"

   initial begin
      clk = 1'b0;
      forever begin
         #(CLK_PERIOD / 2);
         clk = ~clk;
      end
   end

   // *******************************************************************
   // Helpers
   // *******************************************************************
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] s;
      s = x;
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   // Every address bit shows up in the preload word
   function automatic logic [31:0] fill_word(input int i);
      return 32'hC0DE_0000 | (32'(i) << 8) | (32'(i) ^ 32'h2A);
   endfunction

   function automatic logic [31:0] expected_cmd_status();
      logic [31:0] v;
      v = '0;
      v[pci_pkg::CMD_MEM_EN_BIT]    = model_mem_en;
      v[pci_pkg::CMD_INT_DIS_BIT]   = model_int_dis;
      v[16 + pci_pkg::STAT_INT_BIT] = model_irq;
      return v;
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      $display("ERROR at %0d ns: %s got %h expected %h", $time, name, got, exp);
      errors++;
   endtask

   task automatic report_failure(input string what);
      $display("%s at %0d ns", what, $time);
      errors++;
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (errors == test_errors) begin
         $display("Test %0d %s: passed", tests_run, name);
      end else begin
         $display("Test %0d %s: failed with %0d errors", tests_run, name, errors - test_errors);
         tests_failed++;
      end
      test_errors = errors;
   endtask

   task automatic cfg_read(input int index, input int delay, output logic [31:0] value);
      bus_cycle(pci_pkg::CFG_READ, 32'(index) << 2, 1'b1, 4'hF, '0, delay, 1'b0, value, ab, st);
      if (ab) begin
         report_failure("Config read was not claimed");
      end
   endtask

   task automatic cfg_write(input int index, input logic [31:0] value);
      bus_cycle(pci_pkg::CFG_WRITE, 32'(index) << 2, 1'b1, 4'hF, value, 0, 1'b0, rd, ab, st);
      if (ab) begin
         report_failure("Config write was not claimed");
      end
   endtask

   task automatic write_command();
      cfg_write(pci_pkg::CFG_CMD_INDEX, (32'(model_int_dis) << pci_pkg::CMD_INT_DIS_BIT) |
                (32'(model_mem_en) << pci_pkg::CMD_MEM_EN_BIT));
   endtask

   task automatic mem_write(input int i, input logic [3:0] ben, input logic [31:0] value,
                            input int delay);
      bus_cycle(pci_pkg::MEM_WRITE, model_bar | (i << 2), 1'b0, ben, value, delay, 1'b0,
                rd, ab, st);
      if (ab || st) begin
         report_failure("Memory write was aborted or disconnected");
      end
      for (int b = 0; b < 4; b++) begin
         if (ben[b]) begin
            model_mem[i][8*b +: 8] = value[8*b +: 8];
         end
      end
      // Doorbell follows bit 0 whatever the byte enables
      if (i == pci_pkg::DOORBELL_INDEX) begin
         model_irq = value[0];
      end
   endtask

   task automatic mem_read(input int i, input int delay);
      bus_cycle(pci_pkg::MEM_READ, model_bar | (i << 2), 1'b0, 4'hF, '0, delay, 1'b0,
                rd, ab, st);
      if (ab || st) begin
         report_failure("Memory read was aborted or disconnected");
      end
      if (rd !== model_mem[i]) begin
         report_mismatch("ad", rd, model_mem[i]);
      end
   endtask

   task automatic wait_inta(input logic level);
      int n;
      n = 0;
      while ((inta_n !== level) && (n < CYCLE_LIMIT)) begin
         next_cycle();
         n++;
      end
      if (inta_n !== level) begin
         $display("ERROR at %0d ns: inta_n got %b expected %b", $time, inta_n, level);
         errors++;
      end
   endtask

   // *******************************************************************
   // Test sequence
   // *******************************************************************
   initial begin
      rng           = 32'd1425;
      errors        = 0;
      test_errors   = 0;
      tests_run     = 0;
      tests_failed  = 0;
      model_bar     = '0;
      model_mem_en  = 1'b0;
      model_int_dis = 1'b0;
      model_irq     = 1'b0;
      reset         = 1'b1;
      drive_idle();
      repeat (2) @(posedge clk);
      #DRIVE_DELAY;
      reset = 1'b0;
      next_cycle();

      cfg_read(pci_pkg::CFG_ID_INDEX, 0, rd);
      if (rd !== {pci_pkg::DEVICE_ID, pci_pkg::VENDOR_ID}) begin
         report_mismatch("id dword", rd, {pci_pkg::DEVICE_ID, pci_pkg::VENDOR_ID});
      end
      cfg_write(pci_pkg::CFG_BAR0_INDEX, 32'hFFFF_FFFF);
      cfg_read(pci_pkg::CFG_BAR0_INDEX, 0, rd);
      if (rd !== 32'hFFFF_FF00) begin
         report_mismatch("bar0", rd, 32'hFFFF_FF00);
      end
      rng = xorshift32(rng);
      model_bar = rng & 32'hFFFF_FF00;
      cfg_write(pci_pkg::CFG_BAR0_INDEX, model_bar);
      cfg_read(pci_pkg::CFG_BAR0_INDEX, 0, rd);
      if (rd !== model_bar) begin
         report_mismatch("bar0", rd, model_bar);
      end
      model_mem_en = 1'b1;
      write_command();
      cfg_read(pci_pkg::CFG_CMD_INDEX, 0, rd);
      if (rd !== expected_cmd_status()) begin
         report_mismatch("command/status", rd, expected_cmd_status());
      end
      finish_test("config header");

      for (int i = 0; i < pci_pkg::MEM_WORDS; i++) begin
         mem_write(i, 4'hF, fill_word(i), 0);
      end
      for (int i = 0; i < 40; i++) begin
         rng = xorshift32(rng);
         data = rng;
         rng = xorshift32(rng);
         mem_write(int'(rng[5:0]), rng[11:8], data, 0);
      end
      for (int i = 0; i < 40; i++) begin
         rng = xorshift32(rng);
         mem_read(int'(rng[5:0]), 0);
      end
      finish_test("memory write and read");

      // Disabled decode and then an address outside BAR0
      rng = xorshift32(rng);
      idx = int'(rng[5:0]);
      model_mem_en = 1'b0;
      write_command();
      bus_cycle(pci_pkg::MEM_WRITE, model_bar | (idx << 2), 1'b0, 4'hF, ~model_mem[idx], 0,
                1'b0, rd, ab, st);
      if (!ab) begin
         report_failure("Memory write claimed while memory decode was disabled");
      end
      model_mem_en = 1'b1;
      write_command();
      bus_cycle(pci_pkg::MEM_WRITE, (model_bar ^ 32'h8000_0000) | (idx << 2), 1'b0, 4'hF,
                ~model_mem[idx], 0, 1'b0, rd, ab, st);
      if (!ab) begin
         report_failure("Memory write outside BAR0 was claimed");
      end
      mem_read(idx, 0);
      finish_test("master abort");

      for (int i = 0; i < 30; i++) begin
         rng = xorshift32(rng);
         data = rng;
         rng = xorshift32(rng);
         if (rng[16]) begin
            mem_write(int'(rng[5:0]), rng[11:8], data, int'(rng[13:12]));
         end else begin
            mem_read(int'(rng[5:0]), int'(rng[13:12]));
         end
         cfg_read(pci_pkg::CFG_BAR0_INDEX, int'(rng[21:20]), rd);
         if (rd !== model_bar) begin
            report_mismatch("bar0", rd, model_bar);
         end
      end
      finish_test("irdy_n wait states");

      rng = xorshift32(rng);
      idx = int'(rng[5:0]) % 62;
      data = xorshift32(rng);
      bus_cycle(pci_pkg::MEM_WRITE, model_bar | (idx << 2), 1'b0, 4'hF, data,
                int'(rng[9:8]), 1'b1, rd, ab, st);
      if (ab || !st) begin
         report_failure("Burst write was not disconnected with data");
      end
      model_mem[idx] = data;
      mem_read(idx, 0);
      mem_read(idx + 1, 0);
      finish_test("burst disconnect");

      mem_write(pci_pkg::DOORBELL_INDEX, 4'hF, 32'h1, 0);
      wait_inta(1'b0);
      cfg_read(pci_pkg::CFG_CMD_INDEX, 0, rd);
      if (rd !== expected_cmd_status()) begin
         report_mismatch("command/status", rd, expected_cmd_status());
      end
      model_int_dis = 1'b1;
      write_command();
      wait_inta(1'b1);
      cfg_read(pci_pkg::CFG_CMD_INDEX, 0, rd);
      if (rd !== expected_cmd_status()) begin
         report_mismatch("command/status", rd, expected_cmd_status());
      end
      model_int_dis = 1'b0;
      write_command();
      wait_inta(1'b0);
      mem_write(pci_pkg::DOORBELL_INDEX, 4'hF, 32'h0, 0);
      wait_inta(1'b1);
      cfg_read(pci_pkg::CFG_CMD_INDEX, 0, rd);
      if (rd !== expected_cmd_status()) begin
         report_mismatch("command/status", rd, expected_cmd_status());
      end
      finish_test("doorbell interrupt");

      $display("Tests run %0d, tests failed %0d, errors %0d, assertion failures %0d",
               tests_run, tests_failed, errors, dut0.chk0.fired);
      if ((errors == 0) && (dut0.chk0.fired == 0)) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: build.f
+incdir+testbench
rtl/pci_pkg.sv
rtl/pci_cfg_space.sv
rtl/pci_target_fsm.sv
rtl/local_mem_app.sv
rtl/pci_target_top.sv
testbench/pci_target_chk.sv
testbench/pci_target_tb.sv

// File: Makefile
# Verilator build and run of the PCI target testbench

SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = pci_target_tb
FILELIST = build.f
OBJDIR   = obj_dir
RUNOPTS  = +verilator+error+limit+1000

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# Pass only when the pass line appears in the simulator output
run: compile
	@out="$$(./$(OBJDIR)/V$(TOP) $(RUNOPTS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf $(OBJDIR)
